/* Makefile */
SIM      = verilator
TOP      = mips_core_tb
FILELIST = mips_core.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PATTERNS = bench/mips_core_patterns.txt
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(PATTERNS)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/mips_core_patterns.txt */
// record: instruction count, instruction words, write-back count,
// then (register, value) pairs, then halt address; a zero count ends the list
// program 1: arithmetic, wrapping, signed slt, register zero
0000000C
24010005 2402FFFD 00221821 00412023 00222824 00223025
0041382A 0022402A 24000007 00014821 00095023 FC000000
0000000A
00000001 00000005  00000002 FFFFFFFD  00000003 00000002
00000004 FFFFFFF8  00000005 00000005  00000006 FFFFFFFD
00000007 00000001  00000008 00000000  00000009 00000005
0000000A FFFFFFFB
0000000B
// program 2: sw and lw on two addresses, beq taken then not taken
0000000B
24011234 2402FFFF AC010003 AC020004 8C030003 8C040004
10610001 24050001 10620001 24060002 FC000000
00000005
00000001 00001234  00000002 FFFFFFFF  00000003 00001234
00000004 FFFFFFFF  00000006 00000002
0000000A
// program 3: reload, registers start cleared, branch over a halt
00000007
00220821 24420007 10200002 24030009 FC000000 0022182A FC000000
00000003
00000001 00000000  00000002 00000007  00000003 00000001
00000006
// end of list
00000000

/* bench/mips_core_properties.sv */
`timescale 1ns/100ps

module mips_core_properties
(
	input logic            clk,
	input logic            rst_n,
	input mips_pkg::word_t pc,
	input logic            halted,
	input mips_pkg::wb_t   wb
);
	import mips_pkg::*;

	//////////////////////////////////////////////////
	// halt behavior
	//////////////////////////////////////////////////

	// sticky until reset
	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
		else $error("halted fell while out of reset");

	// no register writes once stopped
	halt_no_wb: assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wb.en)
		else $error("write-back while halted");

	// frozen program counter
	halt_pc_hold: assert property (@(posedge clk) disable iff (!rst_n) halted |=> $stable(pc))
		else $error("pc moved while halted");

	//////////////////////////////////////////////////
	// write-back bus
	//////////////////////////////////////////////////

	wb_not_r0: assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> wb.addr != '0)
		else $error("write-back to register zero");

endmodule

bind mips_core mips_core_properties u_props
(
	.clk    (clk),
	.rst_n  (rst_n),
	.pc     (pc),
	.halted (halted),
	.wb     (wb)
);

/* bench/mips_core_tb.sv */
`timescale 1ns/100ps

module mips_core_tb;
	import mips_pkg::*;

	localparam int PAT_WORDS     = 256;
	localparam int MAX_PROGRAMS  = 16;
	localparam int RESET_CYCLES  = 10;
	localparam int HALT_TIMEOUT  = 200;
	localparam int SETTLE_CYCLES = 3;
	localparam int SEED          = 41046;

	logic  clk;
	logic  rst_n;
	logic  load_en;
	word_t load_addr;
	word_t load_data;
	word_t pc;
	logic  halted;
	wb_t   wb;

	// flat record stream from the patterns file
	word_t pat [PAT_WORDS];

	int   ptr;
	int   prog_count;
	int   prog_fails;
	int   prog_errors;
	int   checks;
	int   errors;
	int   idle;
	logic timed_out;

	mips_core #(.IMEM_DEPTH(32), .DMEM_DEPTH(32)) uut
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.pc        (pc),
		.halted    (halted),
		.wb        (wb)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	//////////////////////////////////////////////////
	// program load under reset
	//////////////////////////////////////////////////

	// reset stays low for at least RESET_CYCLES, longer for long programs
	task automatic load_program(input int first, input int count);
		int cycles;
		cycles = (count > RESET_CYCLES) ? count : RESET_CYCLES;
		@(negedge clk);
		rst_n = 1'b0;
		for (int i = 0; i < cycles; i++)
		begin
			if (i < count)
			begin
				load_en   = 1'b1;
				load_addr = i;
				load_data = pat[first + i];
			end
			else
				load_en = 1'b0;
			@(negedge clk);
		end
		load_en = 1'b0;
		rst_n   = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// write-back compare
	//////////////////////////////////////////////////

	// one wb event against the next expected pair
	task automatic compare_wb(input int base, input int count, inout int seen);
		reg_addr_t exp_addr;
		word_t     exp_data;
		if (seen >= count)
		begin
			$display("surplus write-back at %0t: r%0d = %h after the expected list ended",
				$time, wb.addr, wb.data);
			errors++;
			prog_errors++;
		end
		else
		begin
			exp_addr = pat[base + 2 * seen][4:0];
			exp_data = pat[base + 2 * seen + 1];
			checks++;
			if (wb.addr != exp_addr)
			begin
				$display("[FAIL] %0t wb.addr expected %0d got %0d", $time, exp_addr, wb.addr);
				errors++;
				prog_errors++;
			end
			if (wb.data != exp_data)
			begin
				$display("[FAIL] %0t wb.data expected %h got %h", $time, exp_data, wb.data);
				errors++;
				prog_errors++;
			end
			seen++;
		end
	endtask

	//////////////////////////////////////////////////
	// one program, load to halt
	//////////////////////////////////////////////////

	task automatic run_program(input int id);
		int n_instr;
		int n_wb;
		int wb_base;
		int wb_seen;
		int halt_addr;
		int cycles;
		n_instr = pat[ptr];
		load_program(ptr + 1, n_instr);
		ptr     = ptr + 1 + n_instr;
		n_wb    = pat[ptr];
		wb_base = ptr + 1;
		ptr     = wb_base + 2 * n_wb;
		halt_addr = pat[ptr];
		ptr++;
		prog_errors = 0;
		wb_seen     = 0;
		cycles      = 0;
		// sample mid-cycle, the bus holds what commits at the next rising edge
		while (!halted && cycles < HALT_TIMEOUT)
		begin
			@(negedge clk);
			if (wb.en)
				compare_wb(wb_base, n_wb, wb_seen);
			cycles++;
		end
		if (!halted)
		begin
			$display("program %0d: core did not halt within %0d cycles", id, HALT_TIMEOUT);
			timed_out = 1'b1;
			errors++;
			prog_fails++;
		end
		else
		begin
			// a halted core must stay quiet
			for (int i = 0; i < SETTLE_CYCLES; i++)
			begin
				@(negedge clk);
				if (wb.en)
					compare_wb(wb_base, n_wb, wb_seen);
			end
			checks++;
			if (pc != word_t'(halt_addr))
			begin
				$display("[FAIL] %0t pc expected %h got %h", $time, word_t'(halt_addr), pc);
				errors++;
				prog_errors++;
			end
			if (wb_seen < n_wb)
			begin
				$display("program %0d: only %0d of %0d write-backs appeared",
					id, wb_seen, n_wb);
				errors++;
				prog_errors++;
			end
			if (prog_errors != 0)
				prog_fails++;
			$display("program %0d: %s, %0d write-backs, %0d errors",
				id, (prog_errors == 0) ? "ok" : "FAIL", wb_seen, prog_errors);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		ptr         = 0;
		prog_count  = 0;
		prog_fails  = 0;
		prog_errors = 0;
		checks      = 0;
		errors      = 0;
		timed_out   = 1'b0;
		void'($urandom(SEED));
		$readmemh("bench/mips_core_patterns.txt", pat);

		// zero instruction count ends the list
		while (!timed_out && ptr < PAT_WORDS && pat[ptr] != '0
			&& prog_count < MAX_PROGRAMS)
		begin
			prog_count++;
			run_program(prog_count);
			// random gap before the next reset
			idle = $urandom_range(4, 1);
			repeat (idle) @(negedge clk);
		end

		$display("programs %0d, failing %0d, checks %0d, errors %0d",
			prog_count, prog_fails, checks, errors);
		if (errors == 0 && prog_count > 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* common/mips_pkg.sv */
package mips_pkg;

	//////////////////////////////////////////////////
	// basic widths
	//////////////////////////////////////////////////

	// one data or instruction word
	typedef logic [31:0] word_t;

	// register index, 32 registers
	typedef logic [4:0] reg_addr_t;

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	// major opcode, bits 31..26
	typedef enum logic [5:0]
	{
		op_rtype = 6'b000000,
		op_beq   = 6'b000100,
		op_addiu = 6'b001001,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011,
		// all ones stops the core
		op_halt  = 6'b111111
	} opcode_e;

	// function field of register-type ops, bits 5..0
	typedef enum logic [5:0]
	{
		fn_addu = 6'b100001,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_slt  = 6'b101010
	} funct_e;

	// alu operation select
	typedef enum logic [2:0]
	{
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_e;

	//////////////////////////////////////////////////
	// bundles
	//////////////////////////////////////////////////

	// decoded control for one instruction
	typedef struct packed
	{
		logic    reg_write;
		logic    reg_dst_rd;
		logic    alu_src_imm;
		logic    mem_read;
		logic    mem_write;
		logic    branch;
		logic    halt;
		alu_op_e alu_op;
	} ctrl_t;

	// register write-back bus
	typedef struct packed
	{
		logic      en;
		reg_addr_t addr;
		word_t     data;
	} wb_t;

endpackage

/* datapath/alu.sv */
`timescale 1ns/100ps

module alu
(
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	input  mips_pkg::alu_op_e op,
	output mips_pkg::word_t   result,
	output logic              zero
);
	import mips_pkg::*;

	//////////////////////////////////////////////////
	// operation select
	//////////////////////////////////////////////////

	// signed compare for slt
	logic a_lt_b;

	assign a_lt_b = $signed(a) < $signed(b);

	always_comb
	begin
		case (op)
			// add and sub wrap, no overflow trap
			alu_add:
				result = a + b;
			alu_sub:
				result = a - b;

			// bitwise ops
			alu_and:
				result = a & b;
			alu_or:
				result = a | b;

			// one or zero in bit 0
			alu_slt:
				result = {31'd0, a_lt_b};

			default:
				result = '0;
		endcase
	end

	// zero flag, used by beq
	assign zero = (result == '0);

endmodule

/* datapath/register_file.sv */
`timescale 1ns/100ps

module register_file
(
	input  logic              clk,
	input  logic              rst_n,
	input  mips_pkg::reg_addr_t rs_addr,
	input  mips_pkg::reg_addr_t rt_addr,
	input  mips_pkg::wb_t     wb,
	output mips_pkg::word_t   rs_data,
	output mips_pkg::word_t   rt_data
);
	import mips_pkg::*;

	// 32 general registers
	word_t regs [32];

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	// all registers clear on reset
	// register zero is never written and stays zero
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.en && (wb.addr != '0))
		begin
			regs[wb.addr] <= wb.data;
		end
	end

	//////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////

	// combinational, no bypass
	// single cycle core sees the old value until the edge
	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

endmodule

/* hw/data_mem.sv */
`timescale 1ns/100ps

module data_mem
#(
	parameter int DMEM_DEPTH = 32
)
(
	input  logic            clk,
	input  mips_pkg::word_t addr,
	input  mips_pkg::word_t wdata,
	input  logic            we,
	output mips_pkg::word_t rdata
);
	import mips_pkg::*;

	// index width, at least one bit
	localparam int AW = (DMEM_DEPTH > 1) ? $clog2(DMEM_DEPTH) : 1;

	// word storage
	word_t mem [DMEM_DEPTH];

	// word index, address wraps at the depth
	logic [AW-1:0] idx;

	assign idx = AW'(addr % DMEM_DEPTH);

	// store at the end of the cycle
	always_ff @(posedge clk)
	begin
		if (we)
			mem[idx] <= wdata;
	end

	// load is combinational
	assign rdata = mem[idx];

endmodule

/* hw/instruction_mem.sv */
`timescale 1ns/100ps

module instruction_mem
#(
	parameter int IMEM_DEPTH = 32
)
(
	input  logic           clk,
	input  logic           load_en,
	input  mips_pkg::word_t load_addr,
	input  mips_pkg::word_t load_data,
	input  mips_pkg::word_t addr,
	output mips_pkg::word_t instr
);
	import mips_pkg::*;

	// index width, at least one bit
	localparam int AW = (IMEM_DEPTH > 1) ? $clog2(IMEM_DEPTH) : 1;

	// halt opcode with zero fields
	localparam word_t HALT_WORD = {op_halt, 26'd0};

	// word storage, filled through the load port
	word_t mem [IMEM_DEPTH];

	// program load, one word per edge
	// out of range loads are dropped
	always_ff @(posedge clk)
	begin
		if (load_en && (load_addr < IMEM_DEPTH))
			mem[load_addr[AW-1:0]] <= load_data;
	end

	// combinational fetch by word index
	// past the end reads as halt so a runaway program stops
	always_comb
	begin
		if (addr < IMEM_DEPTH)
			instr = mem[addr[AW-1:0]];
		else
			instr = HALT_WORD;
	end

endmodule

/* hw/main_control.sv */
`timescale 1ns/100ps

module main_control
(
	input  mips_pkg::opcode_e opcode,
	input  mips_pkg::funct_e  funct,
	output mips_pkg::ctrl_t   ctrl
);
	import mips_pkg::*;

	//////////////////////////////////////////////////
	// opcode decode
	//////////////////////////////////////////////////

	always_comb
	begin
		// default is a no-op, nothing written
		ctrl             = '0;
		ctrl.alu_op      = alu_add;

		case (opcode)
			op_rtype:
			begin
				// destination is rd, both operands from registers
				ctrl.reg_dst_rd = 1'b1;
				ctrl.reg_write  = 1'b1;
				case (funct)
					fn_addu: ctrl.alu_op = alu_add;
					fn_subu: ctrl.alu_op = alu_sub;
					fn_and:  ctrl.alu_op = alu_and;
					fn_or:   ctrl.alu_op = alu_or;
					fn_slt:  ctrl.alu_op = alu_slt;
					default:
					begin
						// unknown funct, drop the write
						ctrl.reg_write  = 1'b0;
						ctrl.reg_dst_rd = 1'b0;
					end
				endcase
			end

			op_addiu:
			begin
				// rt <= rs + sign extended imm
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = alu_add;
			end

			op_lw:
			begin
				// address from rs + imm, data to rt
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.alu_op      = alu_add;
			end

			op_sw:
			begin
				// same address path, rt goes to memory
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
				ctrl.alu_op      = alu_add;
			end

			op_beq:
			begin
				// compare by subtract, zero flag decides
				ctrl.branch = 1'b1;
				ctrl.alu_op = alu_sub;
			end

			op_halt:
				ctrl.halt = 1'b1;

			default:
				ctrl.halt = 1'b0;
		endcase
	end

endmodule

/* hw/mips_core.sv */
`timescale 1ns/100ps

module mips_core
#(
	parameter int IMEM_DEPTH = 32,
	parameter int DMEM_DEPTH = 32
)
(
	input  logic            clk,
	input  logic            rst_n,
	input  logic            load_en,
	input  mips_pkg::word_t load_addr,
	input  mips_pkg::word_t load_data,
	output mips_pkg::word_t pc,
	output logic            halted,
	output mips_pkg::wb_t   wb
);
	import mips_pkg::*;

	word_t     instr;
	ctrl_t     ctrl;
	word_t     rs_data;
	word_t     rt_data;
	word_t     imm_ext;
	word_t     alu_b;
	word_t     alu_result;
	logic      alu_zero;
	word_t     rd_data;
	reg_addr_t dest;
	word_t     pc_next;
	logic      run;

	//////////////////////////////////////////////////
	// fetch and decode
	//////////////////////////////////////////////////

	instruction_mem #(.IMEM_DEPTH(IMEM_DEPTH)) u_imem
	(
		.clk       (clk),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.addr      (pc),
		.instr     (instr)
	);

	// opcode in 31..26, funct in 5..0
	main_control u_ctrl
	(
		.opcode (opcode_e'(instr[31:26])),
		.funct  (funct_e'(instr[5:0])),
		.ctrl   (ctrl)
	);

	// rs 25..21, rt 20..16
	register_file u_regs
	(
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_addr (instr[25:21]),
		.rt_addr (instr[20:16]),
		.wb      (wb),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	//////////////////////////////////////////////////
	// execute and memory
	//////////////////////////////////////////////////

	// 16 bit immediate, sign extended
	assign imm_ext = {{16{instr[15]}}, instr[15:0]};
	assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_data;

	alu u_alu
	(
		.a      (rs_data),
		.b      (alu_b),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// stores only commit while running
	data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) u_dmem
	(
		.clk   (clk),
		.addr  (alu_result),
		.wdata (rt_data),
		.we    (ctrl.mem_write & run & ~halted),
		.rdata (rd_data)
	);

	//////////////////////////////////////////////////
	// write-back
	//////////////////////////////////////////////////

	// rd for register-type, rt otherwise
	assign dest = ctrl.reg_dst_rd ? instr[15:11] : instr[20:16];

	// writes to register zero never show on the bus
	assign wb.en   = run & ctrl.reg_write & (dest != '0);
	assign wb.addr = dest;
	assign wb.data = ctrl.mem_read ? rd_data : alu_result;

	//////////////////////////////////////////////////
	// program counter
	//////////////////////////////////////////////////

	// hold on halt, branch when taken, else next word
	always_comb
	begin
		if (ctrl.halt)
			pc_next = pc;
		else if (ctrl.branch && alu_zero)
			pc_next = pc + 32'd1 + imm_ext;
		else
			pc_next = pc + 32'd1;
	end

	// run rises one edge after reset release
	// nothing commits before it
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			run    <= 1'b0;
			halted <= 1'b0;
			pc     <= '0;
		end
		else
		begin
			run <= 1'b1;
			if (run)
			begin
				pc <= pc_next;
				// sticky until the next reset
				if (ctrl.halt)
					halted <= 1'b1;
			end
		end
	end

endmodule

/* mips_core.f */
common/mips_pkg.sv
hw/instruction_mem.sv
hw/main_control.sv
datapath/alu.sv
datapath/register_file.sv
hw/data_mem.sv
hw/mips_core.sv
bench/mips_core_properties.sv
bench/mips_core_tb.sv
